// File: rtl/usb_tx_pkg.sv
// Types and constants shared by the USB full-speed transmit path.
// Each module takes what it needs through a wildcard import.
package usb_tx_pkg;

  // Clock cycles per line bit, 48 MHz clock against 12 Mbit/s
  localparam int unsigned BIT_CLKS = 4;

  // Buffering limits
  localparam int unsigned MAX_PKT_BYTES = 64;
  localparam int unsigned REQ_DEPTH     = 2;

  // Protocol constants
  localparam logic [7:0]  SYNC_BYTE  = 8'h80;
  localparam logic [7:0]  EOP_MASK   = 8'b0000_0111;
  localparam logic [15:0] CRC16_POLY = 16'h8005;
  localparam logic [15:0] CRC16_INIT = 16'hffff;

  typedef logic [3:0] pid_t;
  typedef logic [$clog2(MAX_PKT_BYTES + 1)-1:0] pkt_len_t;
  typedef logic [7:0] byte_t;

  // One packet request from the host side
  typedef struct packed {
    pid_t     pid;
    pkt_len_t len;
  } pkt_req_t;

  // Encoded line state ahead of the pin flip
  typedef struct packed {
    logic oe;
    logic d;
    logic se0;
  } line_sym_t;

  // Bus released, line parked in J
  localparam line_sym_t LINE_IDLE = '{oe: 1'b0, d: 1'b1, se0: 1'b0};

endpackage

// File: rtl/usb_tx_fifo.sv
// Synchronous FIFO with valid/ready on both sides.
// The item type is a parameter, so one block holds requests or bytes.

`timescale 1ns/1ns

module usb_tx_fifo #(
  parameter type         item_t = logic [7:0],
  parameter int unsigned DEPTH  = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clr_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  input  item_t in_data_i,
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output item_t out_data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  item_t            mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign in_ready_o  = (count_q != CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap at DEPTH, which need not be a power of two
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

// File: rtl/usb_tx_pkt_queue.sv
// Input side of the transmit path. Buffers requests and payload bytes and
// starts a packet only once its whole payload sits in the data FIFO.

`timescale 1ns/1ns

module usb_tx_pkt_queue
  import usb_tx_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     link_reset_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  pkt_req_t req_i,
  input  logic     data_valid_i,
  output logic     data_ready_o,
  input  byte_t    data_i,
  output logic     pkt_start_o,
  output pid_t     pid_o,
  output logic     tx_data_avail_o,
  input  logic     tx_data_get_i,
  output byte_t    tx_data_o,
  input  logic     pkt_end_i
);

  pkt_req_t head_req;
  logic     head_valid;
  logic     start_ok;
  logic     data_push;
  logic     busy_q;
  logic     pkt_start_q;
  pid_t     pid_q;
  pkt_len_t remain_q;
  pkt_len_t stored_q;

  usb_tx_fifo #(
    .item_t (pkt_req_t),
    .DEPTH  (REQ_DEPTH)
  ) i_req_fifo (
    .clk_i,
    .rst_ni,
    .clr_i       (link_reset_i),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .in_data_i   (req_i),
    .out_valid_o (head_valid),
    .out_ready_i (start_ok),
    .out_data_o  (head_req)
  );

  usb_tx_fifo #(
    .item_t (byte_t),
    .DEPTH  (MAX_PKT_BYTES)
  ) i_data_fifo (
    .clk_i,
    .rst_ni,
    .clr_i       (link_reset_i),
    .in_valid_i  (data_valid_i),
    .in_ready_o  (data_ready_o),
    .in_data_i   (data_i),
    .out_valid_o (),
    .out_ready_i (tx_data_get_i),
    .out_data_o  (tx_data_o)
  );

  assign data_push = data_valid_i & data_ready_o;

  // Head request may go once every byte it needs is already stored
  assign start_ok = !busy_q && head_valid && (stored_q >= head_req.len);

  assign pkt_start_o     = pkt_start_q;
  assign pid_o           = pid_q;
  assign tx_data_avail_o = (remain_q != '0);

  // PID stays put for the whole packet
  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      pid_q <= head_req.pid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      pkt_start_q <= 1'b0;
      remain_q    <= '0;
      stored_q    <= '0;
    end else if (link_reset_i) begin
      busy_q      <= 1'b0;
      pkt_start_q <= 1'b0;
      remain_q    <= '0;
      stored_q    <= '0;
    end else begin
      pkt_start_q <= start_ok;
      if (start_ok) begin
        busy_q <= 1'b1;
      end else if (pkt_end_i) begin
        busy_q <= 1'b0;
      end
      if (start_ok) begin
        remain_q <= head_req.len;
      end else if (tx_data_get_i) begin
        remain_q <= remain_q - pkt_len_t'(1);
      end
      stored_q <= stored_q + pkt_len_t'(data_push) - pkt_len_t'(tx_data_get_i);
    end
  end

endmodule

// File: rtl/usb_fs_tx.sv
// Full-speed packet serializer. Sends SYNC, PID, payload, CRC16 and EOP,
// stuffs a zero after six ones and keeps the NRZI line level.
// The line symbol changes only on the bit strobe from the line driver.

`timescale 1ns/1ns

module usb_fs_tx
  import usb_tx_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      link_reset_i,
  input  logic      bit_strobe_i,
  input  logic      pkt_start_i,
  input  pid_t      pid_i,
  output logic      pkt_end_o,
  input  logic      tx_data_avail_i,
  output logic      tx_data_get_o,
  input  byte_t     tx_data_i,
  output line_sym_t line_o
);

  typedef enum logic [2:0] {st_idle, st_sync, st_pid, st_data, st_crc_hi, st_eop} state_e;
  typedef enum logic [1:0] {os_idle, os_wait, os_tx} out_state_e;

  state_e      state_q, state_d;
  out_state_e  out_q, out_d;
  byte_t       data_sr_q, data_sr_d;
  byte_t       oe_sr_q, oe_sr_d;
  byte_t       se0_sr_q, se0_sr_d;
  logic [2:0]  bit_cnt_q, bit_cnt_d;
  logic [4:0]  hist_q, hist_d;
  logic [5:0]  hist;
  logic        bitstuff;
  logic        stuffed_q, stuffed_d;
  logic        payload_q, payload_d;
  logic        get_q, get_d;
  logic        byte_strobe_q, byte_strobe_d;
  logic [15:0] crc_q, crc_d;
  logic        crc_fb;
  byte_t       crc_lo, crc_hi;
  line_sym_t   line_q, line_d;
  logic        ser_d, ser_oe, ser_se0;
  logic        pkt_end;

  assign ser_d   = data_sr_q[0];
  assign ser_oe  = oe_sr_q[0];
  assign ser_se0 = se0_sr_q[0];

  // Newest bit sits at the top, the current one included
  assign hist     = {ser_d, hist_q};
  assign bitstuff = (hist == 6'b111111);

  assign byte_strobe_d = bit_strobe_i && !bitstuff && !pkt_start_i && (bit_cnt_q == 3'd0);

  ////////////////////////////////////////////////////////////////////////////
  // Byte sequencing and bit shifting
  ////////////////////////////////////////////////////////////////////////////

  // CRC residue goes out MSB first and inverted
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      crc_lo[i] = ~crc_q[15 - i];
      crc_hi[i] = ~crc_q[7 - i];
    end
  end

  always_comb begin
    state_d   = state_q;
    data_sr_d = data_sr_q;
    oe_sr_d   = oe_sr_q;
    se0_sr_d  = se0_sr_q;
    payload_d = payload_q;
    get_d     = 1'b0;
    bit_cnt_d = bit_cnt_q;
    hist_d    = hist_q;
    stuffed_d = stuffed_q;

    // Next byte loads one clock after the last bit of the previous one
    if (byte_strobe_q && state_q != st_idle) begin
      oe_sr_d  = 8'hff;
      se0_sr_d = 8'h00;
      unique case (state_q)
        st_sync: begin
          state_d   = st_pid;
          data_sr_d = SYNC_BYTE;
        end
        st_pid: begin
          data_sr_d = {~pid_i, pid_i};
          // Handshakes carry no data and no CRC
          state_d   = (pid_i[1:0] == 2'b11) ? st_data : st_eop;
        end
        st_data: begin
          if (tx_data_avail_i) begin
            data_sr_d = tx_data_i;
            payload_d = 1'b1;
            get_d     = 1'b1;
          end else begin
            data_sr_d = crc_lo;
            payload_d = 1'b0;
            state_d   = st_crc_hi;
          end
        end
        st_crc_hi: begin
          data_sr_d = crc_hi;
          state_d   = st_eop;
        end
        st_eop: begin
          state_d  = st_idle;
          oe_sr_d  = EOP_MASK;
          se0_sr_d = EOP_MASK;
        end
        default: state_d = st_idle;
      endcase
    end

    if (pkt_start_i) begin
      // Count starts at 7 so one idle bit goes before the byte boundary
      state_d   = st_sync;
      bit_cnt_d = 3'd7;
      hist_d    = '0;
      stuffed_d = 1'b0;
    end else if (bit_strobe_i) begin
      if (bitstuff) begin
        // Sixth one is on the wire, its slot now carries the stuffed zero
        data_sr_d[0] = 1'b0;
      end else begin
        bit_cnt_d = bit_cnt_q + 3'd1;
        data_sr_d = data_sr_q >> 1;
        oe_sr_d   = oe_sr_q >> 1;
        se0_sr_d  = se0_sr_q >> 1;
      end
      hist_d    = hist[5:1];
      stuffed_d = bitstuff;
    end
  end

  // CRC16 over payload bits, skipping stuffed zeros
  assign crc_fb = ser_d ^ crc_q[15];

  always_comb begin
    crc_d = crc_q;
    if (pkt_start_i) begin
      crc_d = CRC16_INIT;
    end else if (bit_strobe_i && payload_q && !stuffed_q) begin
      crc_d = {crc_q[14:0], 1'b0} ^ ({16{crc_fb}} & CRC16_POLY);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // NRZI and EOP output
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    out_d   = out_q;
    line_d  = line_q;
    pkt_end = 1'b0;
    unique case (out_q)
      os_idle: begin
        if (pkt_start_i) begin
          out_d = os_wait;
        end
      end
      os_wait: begin
        if (byte_strobe_q) begin
          out_d = os_tx;
        end
      end
      os_tx: begin
        if (bit_strobe_i) begin
          if (!ser_oe) begin
            line_d  = LINE_IDLE;
            pkt_end = 1'b1;
            out_d   = os_idle;
          end else if (ser_se0) begin
            // Two SE0 bits, then J on the last marked bit
            line_d = '{oe: 1'b1, d: 1'b1, se0: se0_sr_q[1]};
          end else begin
            // Zero toggles the level, one keeps it
            line_d = '{oe: 1'b1, d: ser_d ? line_q.d : ~line_q.d, se0: 1'b0};
          end
        end
      end
      default: out_d = os_idle;
    endcase
  end

  assign pkt_end_o     = pkt_end;
  assign tx_data_get_o = get_q;
  assign line_o        = line_q;

  always_ff @(posedge clk_i) begin
    crc_q <= crc_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= st_idle;
      out_q         <= os_idle;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      bit_cnt_q     <= '0;
      hist_q        <= '0;
      stuffed_q     <= 1'b0;
      payload_q     <= 1'b0;
      get_q         <= 1'b0;
      byte_strobe_q <= 1'b0;
      line_q        <= LINE_IDLE;
    end else if (link_reset_i) begin
      state_q       <= st_idle;
      out_q         <= os_idle;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      bit_cnt_q     <= '0;
      hist_q        <= '0;
      stuffed_q     <= 1'b0;
      payload_q     <= 1'b0;
      get_q         <= 1'b0;
      byte_strobe_q <= 1'b0;
      line_q        <= LINE_IDLE;
    end else begin
      state_q       <= state_d;
      out_q         <= out_d;
      data_sr_q     <= data_sr_d;
      oe_sr_q       <= oe_sr_d;
      se0_sr_q      <= se0_sr_d;
      bit_cnt_q     <= bit_cnt_d;
      hist_q        <= hist_d;
      stuffed_q     <= stuffed_d;
      payload_q     <= payload_d;
      get_q         <= get_d;
      byte_strobe_q <= byte_strobe_d;
      line_q        <= line_d;
    end
  end

endmodule

// File: rtl/usb_tx_line_drv.sv
// Output side of the transmit path. Paces the bit strobe, applies the
// D+/D- pin flip and registers every pad output.

`timescale 1ns/1ns

module usb_tx_line_drv
  import usb_tx_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      link_reset_i,
  input  logic      cfg_pinflip_i,
  output logic      bit_strobe_o,
  input  line_sym_t line_i,
  output logic      usb_oe_o,
  output logic      usb_d_o,
  output logic      usb_se0_o,
  output logic      usb_dp_o,
  output logic      usb_dn_o
);

  localparam int unsigned CNT_W = (BIT_CLKS > 1) ? $clog2(BIT_CLKS) : 1;

  logic [CNT_W-1:0] clk_cnt_q;
  logic             dp;
  logic             dn;

  // Free-running bit clock divider
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clk_cnt_q <= '0;
    end else if (clk_cnt_q == CNT_W'(BIT_CLKS - 1)) begin
      clk_cnt_q <= '0;
    end else begin
      clk_cnt_q <= clk_cnt_q + CNT_W'(1);
    end
  end

  assign bit_strobe_o = (clk_cnt_q == CNT_W'(BIT_CLKS - 1));

  // J drives D+ high, SE0 pulls both low
  assign dp = line_i.d & ~line_i.se0;
  assign dn = ~line_i.d & ~line_i.se0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      usb_oe_o  <= 1'b0;
      usb_d_o   <= 1'b1;
      usb_se0_o <= 1'b0;
      usb_dp_o  <= 1'b1;
      usb_dn_o  <= 1'b0;
    end else if (link_reset_i) begin
      usb_oe_o  <= 1'b0;
      usb_d_o   <= 1'b1;
      usb_se0_o <= 1'b0;
      usb_dp_o  <= ~cfg_pinflip_i;
      usb_dn_o  <= cfg_pinflip_i;
    end else begin
      usb_oe_o  <= line_i.oe;
      usb_d_o   <= line_i.d;
      usb_se0_o <= line_i.se0;
      usb_dp_o  <= cfg_pinflip_i ? dn : dp;
      usb_dn_o  <= cfg_pinflip_i ? dp : dn;
    end
  end

endmodule

// File: rtl/usb_tx_top.sv
// Top level of the USB full-speed transmit path.
// Request and payload ports in, registered pad outputs out.

`timescale 1ns/1ns

module usb_tx_top
  import usb_tx_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     link_reset_i,
  input  logic     cfg_pinflip_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  pkt_req_t req_i,
  input  logic     data_valid_i,
  output logic     data_ready_o,
  input  byte_t    data_i,
  output logic     usb_oe_o,
  output logic     usb_d_o,
  output logic     usb_se0_o,
  output logic     usb_dp_o,
  output logic     usb_dn_o
);

  logic      pkt_start;
  logic      pkt_end;
  pid_t      pid;
  logic      tx_data_avail;
  logic      tx_data_get;
  byte_t     tx_data;
  logic      bit_strobe;
  line_sym_t line;

  usb_tx_pkt_queue i_queue (
    .clk_i,
    .rst_ni,
    .link_reset_i,
    .req_valid_i,
    .req_ready_o,
    .req_i,
    .data_valid_i,
    .data_ready_o,
    .data_i,
    .pkt_start_o     (pkt_start),
    .pid_o           (pid),
    .tx_data_avail_o (tx_data_avail),
    .tx_data_get_i   (tx_data_get),
    .tx_data_o       (tx_data),
    .pkt_end_i       (pkt_end)
  );

  usb_fs_tx i_tx (
    .clk_i,
    .rst_ni,
    .link_reset_i,
    .bit_strobe_i    (bit_strobe),
    .pkt_start_i     (pkt_start),
    .pid_i           (pid),
    .pkt_end_o       (pkt_end),
    .tx_data_avail_i (tx_data_avail),
    .tx_data_get_o   (tx_data_get),
    .tx_data_i       (tx_data),
    .line_o          (line)
  );

  usb_tx_line_drv i_line_drv (
    .clk_i,
    .rst_ni,
    .link_reset_i,
    .cfg_pinflip_i,
    .bit_strobe_o (bit_strobe),
    .line_i       (line),
    .usb_oe_o,
    .usb_d_o,
    .usb_se0_o,
    .usb_dp_o,
    .usb_dn_o
  );

endmodule

// File: verif/usb_tx_tb.sv
// Testbench for the USB full-speed transmit path.
// Pushes requests and payload into the top level, decodes the pads back
// into bytes and compares them with a packet model built from the USB rules.

`timescale 1ns/1ns

module usb_tx_tb
  import usb_tx_pkg::*;
();

  localparam int          LINE_BIT_CLKS = 4;
  localparam int          WAIT_LIMIT    = 40000;
  localparam logic [31:0] SEED          = 32'h41412743;

  logic     clk_i;
  logic     rst_ni;
  logic     link_reset_i;
  logic     cfg_pinflip_i;
  logic     req_valid_i;
  logic     req_ready_o;
  pkt_req_t req_i;
  logic     data_valid_i;
  logic     data_ready_o;
  byte_t    data_i;
  logic     usb_oe_o;
  logic     usb_d_o;
  logic     usb_se0_o;
  logic     usb_dp_o;
  logic     usb_dn_o;

  // Packet model and decoded traffic
  byte_t payload_buf [64];
  byte_t exp_bytes [$];
  int    exp_lens [$];
  byte_t dec_bytes [$];
  int    dec_lens [$];
  int    err_cnt;
  int    sent_cnt;
  int    pkt_done;
  int    stuff_cnt;
  logic  expect_abort;
  logic  abort_seen;
  logic  saw_data_full;

  usb_tx_top i_dut (
    .clk_i,
    .rst_ni,
    .link_reset_i,
    .cfg_pinflip_i,
    .req_valid_i,
    .req_ready_o,
    .req_i,
    .data_valid_i,
    .data_ready_o,
    .data_i,
    .usb_oe_o,
    .usb_d_o,
    .usb_se0_o,
    .usb_dp_o,
    .usb_dn_o
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      err_cnt++;
      stop_run($sformatf("Fail at %0t: %s, got %0h expected %0h",
                         $time, what, actual, expected));
    end
  endtask

  // Bit-serial CRC16 in wire order, LSB of each byte first
  function automatic logic [15:0] crc16_of(input int len);
    logic [15:0] crc;
    logic        fb;
    crc = 16'hffff;
    for (int i = 0; i < len; i++) begin
      for (int b = 0; b < 8; b++) begin
        fb  = payload_buf[i][b] ^ crc[15];
        crc = {crc[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
      end
    end
    return crc;
  endfunction

  // Expected byte stream of one packet, appended to the model queues
  function automatic void model_packet(input pid_t pid, input int len);
    logic [15:0] crc;
    logic [15:0] tx_crc;
    exp_bytes.push_back(8'h80);
    exp_bytes.push_back({~pid, pid});
    if (pid[1:0] == 2'b11) begin
      crc = crc16_of(len);
      for (int i = 0; i < 16; i++) begin
        tx_crc[i] = ~crc[15 - i];
      end
      for (int i = 0; i < len; i++) begin
        exp_bytes.push_back(payload_buf[i]);
      end
      exp_bytes.push_back(tx_crc[7:0]);
      exp_bytes.push_back(tx_crc[15:8]);
      exp_lens.push_back(len + 4);
    end else begin
      exp_lens.push_back(2);
    end
  endfunction

  function automatic void fill_payload(input int len, input logic all_ones);
    for (int i = 0; i < len; i++) begin
      payload_buf[i] = all_ones ? 8'hff : 8'($urandom());
    end
  endfunction

  // D+ and D- as seen without the pin flip, {dp, dn}
  function automatic logic [1:0] pads_unflipped();
    return cfg_pinflip_i ? {usb_dn_o, usb_dp_o} : {usb_dp_o, usb_dn_o};
  endfunction

  task automatic check_idle_pads(input string where);
    check_eq(32'(usb_oe_o), 32'd0, {"usb_oe_o ", where});
    check_eq(32'(usb_d_o), 32'd1, {"usb_d_o ", where});
    check_eq(32'(usb_se0_o), 32'd0, {"usb_se0_o ", where});
    check_eq(32'(usb_dp_o), 32'(!cfg_pinflip_i), {"usb_dp_o ", where});
    check_eq(32'(usb_dn_o), 32'(cfg_pinflip_i), {"usb_dn_o ", where});
    check_eq(32'(req_ready_o), 32'd1, {"req_ready_o ", where});
    check_eq(32'(data_ready_o), 32'd1, {"data_ready_o ", where});
  endtask

  // usb_d_o and usb_se0_o must agree with the unflipped pad pair
  task automatic check_line_outputs(input logic [1:0] pads);
    check_eq(32'(usb_se0_o), 32'(pads == 2'b00), "usb_se0_o against D+/D-");
    if (pads != 2'b00) begin
      check_eq(32'(usb_d_o), 32'(pads[1]), "usb_d_o against D+/D-");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks, entered and left on a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_req(input pid_t pid_v, input pkt_len_t len_v);
    int t = 0;
    req_valid_i <= 1'b1;
    req_i       <= '{pid: pid_v, len: len_v};
    @(negedge clk_i);
    while (!req_ready_o) begin
      t++;
      if (t > WAIT_LIMIT) stop_run("Timeout: request port never became ready");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic send_payload(input int len);
    int t;
    for (int i = 0; i < len; i++) begin
      t = 0;
      data_valid_i <= 1'b1;
      data_i       <= payload_buf[i];
      @(negedge clk_i);
      // Source holds the byte while the FIFO is full
      while (!data_ready_o) begin
        saw_data_full = 1'b1;
        t++;
        if (t > WAIT_LIMIT) stop_run("Timeout: payload port never became ready");
        @(negedge clk_i);
      end
      @(posedge clk_i);
    end
    data_valid_i <= 1'b0;
  endtask

  task automatic send_packet(input pid_t pid, input int len, input logic all_ones);
    fill_payload(len, all_ones);
    model_packet(pid, len);
    sent_cnt++;
    send_req(pid, pkt_len_t'(len));
    send_payload(len);
  endtask

  task automatic wait_packets(input int n);
    int t = 0;
    while (pkt_done < n) begin
      t++;
      if (t > WAIT_LIMIT) stop_run("Timeout: not every packet arrived on the pads");
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Line decoder and compare
  ////////////////////////////////////////////////////////////////////////////

  initial begin : line_decoder
    byte_t      got [$];
    byte_t      cur;
    logic [1:0] pads;
    logic       prev;
    logic       bit_v;
    logic       aborted;
    int         ones;
    int         nbits;
    int         t;
    forever begin
      t = 0;
      @(negedge clk_i);
      // Timeout only counts while a packet is outstanding
      while (!usb_oe_o) begin
        if (exp_lens.size() > dec_lens.size() || expect_abort) t++;
        if (t > WAIT_LIMIT) stop_run("Timeout: no packet started on the pads");
        @(negedge clk_i);
      end
      if (exp_lens.size() <= dec_lens.size() && !expect_abort) begin
        stop_run("A packet started on the pads with none requested");
      end
      prev    = 1'b1;
      ones    = 0;
      nbits   = 0;
      cur     = '0;
      aborted = 1'b0;
      got.delete();
      // Sample each bit near the middle of its window
      @(negedge clk_i);
      forever begin
        if (!usb_oe_o) begin
          aborted = 1'b1;
          break;
        end
        pads = pads_unflipped();
        if (pads == 2'b11) stop_run("D+ and D- both high during a packet");
        check_line_outputs(pads);
        if (pads == 2'b00) break;
        bit_v = (pads[1] == prev);
        prev  = pads[1];
        if (ones == 6) begin
          check_eq(32'(bit_v), 32'd0, "stuffed bit after six ones");
          stuff_cnt++;
          ones = 0;
        end else begin
          ones  = bit_v ? ones + 1 : 0;
          cur   = {bit_v, cur[7:1]};
          nbits++;
          if (nbits == 8) begin
            got.push_back(cur);
            nbits = 0;
          end
        end
        if (got.size() > 70) stop_run("Packet runs past the largest legal length");
        repeat (LINE_BIT_CLKS) @(negedge clk_i);
      end
      if (aborted) begin
        if (!expect_abort) stop_run("usb_oe_o fell in the middle of a packet");
        expect_abort = 1'b0;
        abort_seen   = 1'b1;
      end else begin
        check_eq(32'(nbits), 32'd0, "bits left over before EOP");
        repeat (LINE_BIT_CLKS) @(negedge clk_i);
        check_eq(32'(pads_unflipped()), 32'h0, "second SE0 bit of EOP");
        check_line_outputs(pads_unflipped());
        repeat (LINE_BIT_CLKS) @(negedge clk_i);
        check_eq(32'(pads_unflipped()), 32'h2, "J bit after SE0");
        check_line_outputs(pads_unflipped());
        check_eq(32'(usb_oe_o), 32'd1, "usb_oe_o during J of EOP");
        t = 0;
        while (usb_oe_o) begin
          t++;
          if (t > 2 * LINE_BIT_CLKS) stop_run("Timeout: usb_oe_o stayed high after EOP");
          @(negedge clk_i);
        end
        foreach (got[i]) begin
          dec_bytes.push_back(got[i]);
        end
        dec_lens.push_back(got.size());
      end
    end
  end

  initial begin : compare_proc
    int n;
    int t;
    t = 0;
    forever begin
      @(negedge clk_i);
      if (dec_lens.size() == 0) begin
        t = (exp_lens.size() != 0) ? t + 1 : 0;
        if (t > WAIT_LIMIT) stop_run("Timeout: expected packet was never decoded");
      end else begin
        t = 0;
        n = dec_lens.pop_front();
        check_eq(32'(n), 32'(exp_lens.pop_front()), $sformatf("length of packet %0d", pkt_done));
        for (int i = 0; i < n; i++) begin
          check_eq(32'(dec_bytes.pop_front()), 32'(exp_bytes.pop_front()),
                   $sformatf("byte %0d of packet %0d", i, pkt_done));
        end
        pkt_done++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int unsigned seed_ret;
    int          len;
    int          stuff_before;
    int          t;
    rst_ni        = 1'b0;
    link_reset_i  = 1'b0;
    cfg_pinflip_i = 1'b0;
    req_valid_i   = 1'b0;
    req_i         = '0;
    data_valid_i  = 1'b0;
    data_i        = '0;
    err_cnt       = 0;
    sent_cnt      = 0;
    pkt_done      = 0;
    stuff_cnt     = 0;
    expect_abort  = 1'b0;
    abort_seen    = 1'b0;
    saw_data_full = 1'b0;
    seed_ret      = $urandom(SEED);
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_idle_pads("after reset");
    @(posedge clk_i);

    // Handshakes, ACK then NAK
    send_packet(4'h2, 0, 1'b0);
    send_packet(4'hA, 0, 1'b0);
    wait_packets(sent_cnt);

    // DATA0 and DATA1, empty, full size, then random sizes
    for (int i = 0; i < 10; i++) begin
      len = (i == 0) ? 0 : (i == 1) ? 64 : int'($urandom_range(64, 0));
      send_packet(i[0] ? 4'hB : 4'h3, len, 1'b0);
      wait_packets(sent_cnt);
    end

    // Runs of ones need stuffed bits
    stuff_before = stuff_cnt;
    send_packet(4'h3, 1, 1'b1);
    send_packet(4'hB, 7, 1'b1);
    send_packet(4'h3, 64, 1'b1);
    wait_packets(sent_cnt);
    check_eq(32'(stuff_cnt > stuff_before), 32'd1, "stuffed bits on the line");

    // Back to back, payload port stalls on a full data FIFO
    saw_data_full = 1'b0;
    send_packet(4'h3, 64, 1'b0);
    send_packet(4'hB, 64, 1'b0);
    send_packet(4'h3, 30, 1'b0);
    send_packet(4'hB, 64, 1'b0);
    wait_packets(sent_cnt);
    check_eq(32'(saw_data_full), 32'd1, "data_ready_o low under back-pressure");

    cfg_pinflip_i <= 1'b1;
    repeat (2) @(negedge clk_i);
    check_idle_pads("with pin flip");
    @(posedge clk_i);
    for (int i = 0; i < 3; i++) begin
      send_packet(i[0] ? 4'hB : 4'h3, int'($urandom_range(64, 0)), 1'b0);
    end
    wait_packets(sent_cnt);

    // Packet cut short by a link reset
    expect_abort = 1'b1;
    fill_payload(40, 1'b0);
    send_req(4'h3, 7'd40);
    send_payload(40);
    t = 0;
    while (!usb_oe_o) begin
      t++;
      if (t > WAIT_LIMIT) stop_run("Timeout: packet before link reset never started");
      @(negedge clk_i);
    end
    repeat (100) @(posedge clk_i);
    link_reset_i <= 1'b1;
    @(posedge clk_i);
    link_reset_i <= 1'b0;
    t = 0;
    while (!abort_seen) begin
      t++;
      if (t > WAIT_LIMIT) stop_run("Timeout: link reset did not end the packet");
      @(negedge clk_i);
    end
    @(negedge clk_i);
    check_idle_pads("after link reset");
    @(posedge clk_i);
    send_packet(4'hB, 20, 1'b0);
    wait_packets(sent_cnt);

    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
rtl/usb_tx_pkg.sv
rtl/usb_tx_fifo.sv
rtl/usb_tx_pkt_queue.sv
rtl/usb_fs_tx.sv
rtl/usb_tx_line_drv.sv
rtl/usb_tx_top.sv
verif/usb_tx_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := usb_tx_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
